// File: hdl/frame_dma_pkg.sv
//============================================================
// Shared types, constants and colour-bar lookup for the DMA
// frame readout path, imported by the pclk_div2 RTL blocks
//============================================================
`default_nettype none

package frame_dma_pkg;

	typedef logic [127:0] dma_word_t;	// Eight RGB565 pixels
	typedef logic [15:0]  rgb565_t;		// BGR565 bit order

	localparam int PIX_PER_WORD  = 8;
	localparam int FSYNC_STRETCH = 31;	// Read fsync length in cycles
	localparam int NUM_BARS      = 8;

	// Read session state
	typedef enum logic {
		SESS_IDLE   = 1'b0,
		SESS_ACTIVE = 1'b1
	} sess_state_e;

	//============================================================
	// Bar colours, BGR565 so red sits in the low bits
	//============================================================
	localparam rgb565_t COLOR_RED     = 16'h001F;
	localparam rgb565_t COLOR_GREEN   = 16'h07E0;
	localparam rgb565_t COLOR_BLUE    = 16'hF800;
	localparam rgb565_t COLOR_YELLOW  = 16'h07FF;
	localparam rgb565_t COLOR_CYAN    = 16'hFFE0;
	localparam rgb565_t COLOR_MAGENTA = 16'hF81F;
	localparam rgb565_t COLOR_WHITE   = 16'hFFFF;
	localparam rgb565_t COLOR_BLACK   = 16'h0000;

	// Left to right bar order
	localparam rgb565_t BAR_COLORS [NUM_BARS] = '{
		COLOR_RED, COLOR_GREEN, COLOR_BLUE, COLOR_YELLOW,
		COLOR_CYAN, COLOR_MAGENTA, COLOR_WHITE, COLOR_BLACK
	};

	// Colour of pixel x for bars of bar_width pixels
	function automatic rgb565_t color_bar_bgr565(input int unsigned x,
			input int unsigned bar_width);
		int unsigned idx;
		idx = x / bar_width;
		if (idx > NUM_BARS - 1)
			idx = NUM_BARS - 1;	// Past the last bar stays black
		return BAR_COLORS[idx];
	endfunction

endpackage

`default_nettype wire

// File: hdl/dma_read_session.sv
//============================================================
// DMA read session: opens on command start, counts one frame
// of read words, stretches the read frame sync at the start
//============================================================
`timescale 1ns/10ps
`default_nettype none

module dma_read_session #(
	parameter int H_WORDS = 160,
	parameter int V_LINES = 720
) (
	input  wire logic pclk_div2,
	input  wire logic core_rst_n,
	input  wire logic i_cmd_start,		// One-cycle DMA start
	input  wire logic i_rd_en,			// Per-word read strobe
	output logic      o_session_start,
	output logic      o_session_active,
	output logic      o_rd_fsync
);

	import frame_dma_pkg::*;

	localparam int FRAME_WORDS = H_WORDS * V_LINES;
	localparam int CNT_W       = $clog2(FRAME_WORDS + 1);
	localparam int STR_W       = $clog2(FSYNC_STRETCH + 1);

	sess_state_e      state_q;
	logic [CNT_W-1:0] word_cnt_q;
	logic [STR_W-1:0] stretch_q;
	logic             last_word;

	// Starts while a frame is still in flight are dropped
	assign o_session_start = i_cmd_start && (state_q == SESS_IDLE);
	assign last_word       = (word_cnt_q == CNT_W'(FRAME_WORDS - 1));

	//============================================================
	// Session FSM and frame word counter
	//============================================================
	always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
		if (!core_rst_n) begin
			state_q    <= SESS_IDLE;
			word_cnt_q <= '0;
		end else begin
			case (state_q)
				SESS_IDLE: begin
					if (o_session_start) begin
						state_q    <= SESS_ACTIVE;
						word_cnt_q <= '0;
					end
				end
				SESS_ACTIVE: begin
					if (i_rd_en) begin
						if (last_word) begin	// Frame consumed
							state_q    <= SESS_IDLE;
							word_cnt_q <= '0;
						end else begin
							word_cnt_q <= word_cnt_q + CNT_W'(1);
						end
					end
				end
				default: state_q <= SESS_IDLE;
			endcase
		end
	end

	// Frame sync stretch, loaded on an accepted start
	always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
		if (!core_rst_n)
			stretch_q <= '0;
		else if (o_session_start)
			stretch_q <= STR_W'(FSYNC_STRETCH);
		else if (stretch_q != '0)
			stretch_q <= stretch_q - STR_W'(1);
	end

	assign o_session_active = (state_q == SESS_ACTIVE);
	assign o_rd_fsync       = (stretch_q != '0);

endmodule

`default_nettype wire

// File: hdl/bar_pattern_gen.sv
//============================================================
// Post-DDR colour-bar source, the word coordinate steps on
// each read strobe and selects the bar colour of the word
//============================================================
`timescale 1ns/10ps
`default_nettype none

module bar_pattern_gen #(
	parameter int H_WORDS       = 160,
	parameter int V_LINES       = 720,
	parameter int BAR_WIDTH_PIX = 160
) (
	input  wire logic                pclk_div2,
	input  wire logic                core_rst_n,
	input  wire logic                i_session_start,	// Restart coordinates
	input  wire logic                i_rd_en,
	output frame_dma_pkg::dma_word_t o_pattern_word
);

	import frame_dma_pkg::*;

	localparam int X_W     = (H_WORDS > 1) ? $clog2(H_WORDS) : 1;
	localparam int PIX_X_W = X_W + $clog2(PIX_PER_WORD);

	logic [X_W-1:0]     word_x_q;
	logic [PIX_X_W-1:0] pix_x;
	logic               x_wrap;
	rgb565_t            bar_color;

	assign x_wrap = (word_x_q == X_W'(H_WORDS - 1));

	//============================================================
	// Coordinate counter
	//============================================================
	always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
		if (!core_rst_n) begin
			word_x_q <= '0;
		end else if (i_session_start) begin
			word_x_q <= '0;
		end else if (i_rd_en) begin	// Runs with or without a session
			if (x_wrap) begin
				word_x_q <= '0;
			end else begin
				word_x_q <= word_x_q + X_W'(1);
			end
		end
	end

	// First pixel of the current word
	assign pix_x = PIX_X_W'(word_x_q) * PIX_X_W'(PIX_PER_WORD);

	assign bar_color = color_bar_bgr565(pix_x, BAR_WIDTH_PIX);

	// Same colour in all pixel slots, bars are word aligned
	assign o_pattern_word = {PIX_PER_WORD{bar_color}};

endmodule

`default_nettype wire

// File: hdl/link_led_blink.sv
//============================================================
// Link LED, blinks while both PCIe link-up flags are high
//============================================================
`timescale 1ns/10ps
`default_nettype none

module link_led_blink #(
	parameter int LED_CNT_WIDTH = 27
) (
	input  wire logic pclk_div2,
	input  wire logic core_rst_n,
	input  wire logic i_smlh_link_up,
	input  wire logic i_rdlh_link_up,
	output logic      o_led
);

	logic [LED_CNT_WIDTH-1:0] blink_cnt_q;
	logic                     link_ok;

	assign link_ok = i_smlh_link_up & i_rdlh_link_up;

	// Counter frozen while the link is down
	always_ff @(posedge pclk_div2 or negedge core_rst_n) begin
		if (!core_rst_n) begin
			blink_cnt_q <= '0;
			o_led       <= 1'b1;	// LED lit out of reset
		end else if (link_ok) begin
			blink_cnt_q <= blink_cnt_q + LED_CNT_WIDTH'(1);
			if (&blink_cnt_q)
				o_led <= ~o_led;	// Once per counter wrap
		end
	end

endmodule

`default_nettype wire

// File: hdl/frame_dma_source.sv
//============================================================
// DMA frame readout top, feeds the read word from frame data
// or from the colour-bar pattern and drives the link LED
//============================================================
`timescale 1ns/10ps
`default_nettype none

module frame_dma_source #(
	parameter int H_WORDS       = 160,	// DMA words per line
	parameter int V_LINES       = 720,
	parameter int BAR_WIDTH_PIX = 160,
	parameter int LED_CNT_WIDTH = 27
) (
	input  wire logic                     pclk_div2,
	input  wire logic                     core_rst_n,
	input  wire logic                     i_cmd_start,
	input  wire logic                     i_rd_en,
	input  wire frame_dma_pkg::dma_word_t i_frame_data,	// Frame buffer read data
	input  wire logic                     i_pattern_en,
	input  wire logic                     i_smlh_link_up,
	input  wire logic                     i_rdlh_link_up,
	output frame_dma_pkg::dma_word_t      o_rd_data,
	output logic                          o_rd_fsync,
	output logic                          o_session_active,
	output logic                          o_led
);

	import frame_dma_pkg::*;

	logic      session_start;
	dma_word_t pattern_word;

	//============================================================
	// Read session control
	//============================================================
	dma_read_session #(
		.H_WORDS			(H_WORDS),
		.V_LINES			(V_LINES)
	) u_dma_read_session (
		.pclk_div2			(pclk_div2),
		.core_rst_n			(core_rst_n),
		.i_cmd_start		(i_cmd_start),
		.i_rd_en			(i_rd_en),
		.o_session_start	(session_start),
		.o_session_active	(o_session_active),
		.o_rd_fsync			(o_rd_fsync)
	);

	// Colour-bar test pattern
	bar_pattern_gen #(
		.H_WORDS			(H_WORDS),
		.V_LINES			(V_LINES),
		.BAR_WIDTH_PIX		(BAR_WIDTH_PIX)
	) u_bar_pattern_gen (
		.pclk_div2			(pclk_div2),
		.core_rst_n			(core_rst_n),
		.i_session_start	(session_start),
		.i_rd_en			(i_rd_en),
		.o_pattern_word		(pattern_word)
	);

	link_led_blink #(
		.LED_CNT_WIDTH		(LED_CNT_WIDTH)
	) u_link_led_blink (
		.pclk_div2			(pclk_div2),
		.core_rst_n			(core_rst_n),
		.i_smlh_link_up		(i_smlh_link_up),
		.i_rdlh_link_up		(i_rdlh_link_up),
		.o_led				(o_led)
	);

	// DMA expects 1-cycle read latency from rd_en, which the
	// coordinate step supplies. A register stage here would
	// repeat a word at every packet boundary.
	assign o_rd_data = i_pattern_en ? pattern_word : i_frame_data;

endmodule

`default_nettype wire

// File: dv/frame_dma_source_sva.sv
//============================================================
// Session and read frame sync timing assertions, bound into
// every dma_read_session instance
//============================================================
`timescale 1ns/10ps
`default_nettype none

module frame_dma_source_sva (
	input wire logic pclk_div2,
	input wire logic core_rst_n,
	input wire logic i_rd_en,
	input wire logic i_session_start,
	input wire logic i_session_active,
	input wire logic i_rd_fsync
);

	import frame_dma_pkg::*;

	// Accepted start opens the session and the sync together
	start_opens_session: assert property (
		@(posedge pclk_div2) disable iff (!core_rst_n)
		i_session_start |=> (i_session_active && i_rd_fsync)
	) else $error("session or fsync not high one cycle after start");

	// Sync stretch length
	fsync_stretch_len: assert property (
		@(posedge pclk_div2) disable iff (!core_rst_n)
		i_session_start |=> i_rd_fsync [*FSYNC_STRETCH] ##1 !i_rd_fsync
	) else $error("fsync stretch not exactly %0d cycles", FSYNC_STRETCH);

	// Frame closes only on a read strobe
	session_ends_on_read: assert property (
		@(posedge pclk_div2) disable iff (!core_rst_n)
		$fell(i_session_active) |-> $past(i_rd_en)
	) else $error("session closed without a read strobe");

endmodule

bind dma_read_session frame_dma_source_sva i_frame_dma_source_sva (
	.pclk_div2			(pclk_div2),
	.core_rst_n			(core_rst_n),
	.i_rd_en			(i_rd_en),
	.i_session_start	(o_session_start),
	.i_session_active	(o_session_active),
	.i_rd_fsync			(o_rd_fsync)
);

`default_nettype wire

// File: dv/frame_dma_source_tb.sv
//============================================================
// Table-driven testbench for the DMA frame readout top, with a
// reference model of session, pattern coordinates and link LED
//============================================================
`timescale 1ns/10ps
`default_nettype none

module frame_dma_source_tb;

	import frame_dma_pkg::*;

	localparam int H_WORDS         = 16;
	localparam int V_LINES         = 4;
	localparam int BAR_WIDTH_PIX   = 16;
	localparam int LED_CNT_WIDTH   = 4;
	localparam int CLK_PERIOD      = 10;
	localparam int RST_CYCLES      = 8;
	localparam int NUM_TESTS       = 7;
	localparam int EXTRA_START_CYC = 10;	// Second start lands mid-stretch
	localparam int MARGIN_CYCLES   = 100;

	typedef struct packed {
		logic       pattern_en;
		logic       do_start;
		int         num_rd;
		logic       extra_start;
		logic [1:0] link_up;		// {smlh, rdlh}
		int         num_cycles;
	} test_row_t;

	// Pattern, start, reads, extra start, link, cycles
	test_row_t tests [NUM_TESTS] = '{
		'{1'b0, 1'b1, 64, 1'b0, 2'b00, 80},
		'{1'b0, 1'b1, 64, 1'b1, 2'b11, 80},
		'{1'b1, 1'b1, 70, 1'b0, 2'b11, 80},
		'{1'b1, 1'b1, 64, 1'b0, 2'b01, 80},
		'{1'b0, 1'b0, 30, 1'b0, 2'b10, 40},
		'{1'b0, 1'b0, 0,  1'b0, 2'b11, 48},
		'{1'b1, 1'b0, 20, 1'b0, 2'b00, 30}
	};
	string test_names [NUM_TESTS] = '{
		"frame_session", "start_while_active", "test_pattern", "pattern_restart",
		"frame_pass_through", "link_led", "pattern_without_session"
	};

	logic      pclk_div2 = 1'b0;
	logic      core_rst_n;
	logic      cmd_start;
	logic      rd_en;
	logic      pattern_en;
	logic      smlh_link_up;
	logic      rdlh_link_up;
	dma_word_t frame_data;
	dma_word_t rd_data;
	logic      rd_fsync;
	logic      session_active;
	logic      led;

	// Reference model, starts in the reset state
	logic exp_active  = 1'b0;
	int   exp_words   = 0;
	int   exp_stretch = 0;
	int   exp_x       = 0;
	int   exp_led_cnt = 0;
	logic exp_led     = 1'b1;

	int err_count  = 0;
	int pass_count = 0;
	int fail_count = 0;

	always #(CLK_PERIOD / 2) pclk_div2 = ~pclk_div2;

	frame_dma_source #(
		.H_WORDS			(H_WORDS),
		.V_LINES			(V_LINES),
		.BAR_WIDTH_PIX		(BAR_WIDTH_PIX),
		.LED_CNT_WIDTH		(LED_CNT_WIDTH)
	) i_frame_dma_source (
		.pclk_div2			(pclk_div2),
		.core_rst_n			(core_rst_n),
		.i_cmd_start		(cmd_start),
		.i_rd_en			(rd_en),
		.i_frame_data		(frame_data),
		.i_pattern_en		(pattern_en),
		.i_smlh_link_up		(smlh_link_up),
		.i_rdlh_link_up		(rdlh_link_up),
		.o_rd_data			(rd_data),
		.o_rd_fsync			(rd_fsync),
		.o_session_active	(session_active),
		.o_led				(led)
	);

	task automatic compare_word(input dma_word_t got, input dma_word_t exp, input string msg);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s got %h expected %h", $time, msg, got, exp);
			err_count++;
		end
	endtask

	task automatic compare_flag(input logic got, input logic exp, input string msg);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s got %b expected %b", $time, msg, got, exp);
			err_count++;
		end
	endtask

	task automatic compare_state(input sess_state_e got, input sess_state_e exp,
			input string msg);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s got %s expected %s", $time, msg,
				got.name(), exp.name());
			err_count++;
		end
	endtask

	// Drive one cycle, check outputs mid-low, then step the model
	task automatic apply_cycle(input logic start, input logic rd, input logic pat,
			input logic [1:0] link);
		logic        accept;
		rgb565_t     bar;
		dma_word_t   exp_data;
		sess_state_e got_state;
		sess_state_e exp_state;
		@(negedge pclk_div2);
		cmd_start    = start;
		rd_en        = rd;
		pattern_en   = pat;
		smlh_link_up = link[1];
		rdlh_link_up = link[0];
		frame_data   = {$urandom(), $urandom(), $urandom(), $urandom()};
		#2;
		bar       = color_bar_bgr565(exp_x * PIX_PER_WORD, BAR_WIDTH_PIX);
		exp_data  = pat ? {PIX_PER_WORD{bar}} : frame_data;
		got_state = session_active ? SESS_ACTIVE : SESS_IDLE;
		exp_state = exp_active ? SESS_ACTIVE : SESS_IDLE;
		compare_word(rd_data, exp_data, "read data");
		compare_state(got_state, exp_state, "session state");
		compare_flag(rd_fsync, exp_stretch != 0, "read fsync");
		compare_flag(led, exp_led, "link led");

		accept = start && !exp_active;	// Starts only from idle
		if (exp_stretch != 0)
			exp_stretch--;
		if (accept) begin
			exp_active  = 1'b1;
			exp_words   = 0;
			exp_stretch = FSYNC_STRETCH;
			exp_x       = 0;
		end else begin
			if (exp_active && rd) begin
				if (exp_words == H_WORDS * V_LINES - 1) begin
					exp_active = 1'b0;
					exp_words  = 0;
				end else begin
					exp_words++;
				end
			end
			if (rd) begin	// Coordinates step with or without a session
				if (exp_x == H_WORDS - 1) begin
					exp_x = 0;
				end else begin
					exp_x++;
				end
			end
		end
		if (link == 2'b11) begin
			if (exp_led_cnt == (1 << LED_CNT_WIDTH) - 1) begin
				exp_led     = ~exp_led;
				exp_led_cnt = 0;
			end else begin
				exp_led_cnt++;
			end
		end
	endtask

	//============================================================
	// Watchdog
	//============================================================
	initial begin
		int limit;
		limit = RST_CYCLES + MARGIN_CYCLES;
		foreach (tests[i])
			limit += tests[i].num_cycles;
		#(limit * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d clock cycles", limit);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		int   err_before;
		logic start;
		logic rd;
		void'($urandom(64));
		core_rst_n   = 1'b0;
		cmd_start    = 1'b0;
		rd_en        = 1'b0;
		pattern_en   = 1'b0;
		smlh_link_up = 1'b0;
		rdlh_link_up = 1'b0;
		frame_data   = '0;
		repeat (RST_CYCLES) @(posedge pclk_div2);
		@(negedge pclk_div2);
		core_rst_n = 1'b1;
		#2;
		err_before = err_count;
		compare_flag(session_active, 1'b0, "active after reset");
		compare_flag(rd_fsync, 1'b0, "fsync after reset");
		compare_flag(led, 1'b1, "led after reset");
		if (err_count == err_before) begin
			pass_count++;
			$display("test reset_state: ok");
		end else begin
			fail_count++;
			$display("test reset_state: FAILED");
		end

		for (int t = 0; t < NUM_TESTS; t++) begin
			err_before = err_count;
			for (int c = 0; c < tests[t].num_cycles; c++) begin
				start = (tests[t].do_start && c == 0) ||
					(tests[t].extra_start && c == EXTRA_START_CYC);
				rd    = (c >= 1) && (c <= tests[t].num_rd);
				apply_cycle(start, rd, tests[t].pattern_en, tests[t].link_up);
			end
			if (err_count == err_before) begin
				pass_count++;
				$display("test %s: ok", test_names[t]);
			end else begin
				fail_count++;
				$display("test %s: FAILED with %0d errors", test_names[t],
					err_count - err_before);
			end
		end

		$display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && err_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
hdl/frame_dma_pkg.sv
hdl/dma_read_session.sv
hdl/bar_pattern_gen.sv
hdl/link_led_blink.sv
hdl/frame_dma_source.sv
dv/frame_dma_source_sva.sv
dv/frame_dma_source_tb.sv

// File: Bender.yml
package:
  name: frame_dma_source

sources:
  # Design
  - hdl/frame_dma_pkg.sv
  - hdl/dma_read_session.sv
  - hdl/bar_pattern_gen.sv
  - hdl/link_led_blink.sv
  - hdl/frame_dma_source.sv

  # Verification
  - target: simulation
    files:
      - dv/frame_dma_source_sva.sv
      - dv/frame_dma_source_tb.sv
